// File: common/fpdiv_pre_pkg.sv
// Shared definitions for the divide/square-root operand preparation stage
// Format widths, field positions, enums and the structs passed between blocks

package fpdiv_pre_pkg;

   //////////////////////////////////////////////////
   // Datapath widths
   //////////////////////////////////////////////////

   // Raw operand, FP32 sized
   localparam int OP_W    = 32;
   // Half-width operand container for FP16 and FP16ALT
   localparam int HALF_W  = 16;
   // Internal exponent and stored mantissa, FP32 fields
   localparam int EXP_W   = 8;
   localparam int MANT_W  = 23;
   // Normalized exponent, one extra bit for the two's complement sign
   localparam int NEXP_W  = EXP_W + 1;
   // Mantissa with the hidden bit in front
   localparam int NMANT_W = MANT_W + 1;
   // Enough to count up to NMANT_W-1 leading zeros
   localparam int LZC_W   = 5;

   // FP16 fields
   localparam int EXP_W_FP16     = 5;
   localparam int MANT_W_FP16    = 10;
   // FP16ALT (bfloat16) fields
   localparam int EXP_W_FP16ALT  = 8;
   localparam int MANT_W_FP16ALT = 7;

   //////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////

   // Operand format, code 1 is unused and handled as FP32
   typedef enum logic [1:0] {
      FMT_FP32    = 2'd0,
      FMT_FP16    = 2'd2,
      FMT_FP16ALT = 2'd3
   } fmt_e;

   // Rounding mode, passed through to the iterative core
   typedef enum logic [2:0] {
      RM_RNE = 3'd0,
      RM_RTZ = 3'd1,
      RM_RDN = 3'd2,
      RM_RUP = 3'd3,
      RM_RMM = 3'd4
   } rm_e;

   //////////////////////////////////////////////////
   // Structs
   //////////////////////////////////////////////////

   // One operand after unpacking, mantissa left-justified
   typedef struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [MANT_W-1:0] mant;
      logic              hidden;
      logic              exp_ones;
      logic              mant_zero;
      logic              mant_msb;
      logic              mant_rest_nz;
   } unpacked_op_t;

   // Classification of both operands
   typedef struct packed {
      logic zero_a;
      logic zero_b;
      logic inf_a;
      logic inf_b;
      logic nan_a;
      logic nan_b;
      logic snan;
   } class_flags_t;

   // Everything handed over to the iterative core
   typedef struct packed {
      logic               sign_z;
      rm_e                rm;
      class_flags_t       flags;
      logic [NEXP_W-1:0]  exp_a;
      logic [NEXP_W-1:0]  exp_b;
      logic [NMANT_W-1:0] mant_a;
      logic [NMANT_W-1:0] mant_b;
   } pre_result_t;

endpackage

// File: hw/preprocess/operand_unpack.sv
// Operand unpacker
// Splits one raw operand into sign, exponent and padded mantissa for the
// selected format and forms the raw field flags

`timescale 1ns/1ns

module operand_unpack
(
   input  logic [fpdiv_pre_pkg::OP_W-1:0] operand,
   input  fpdiv_pre_pkg::fmt_e            fmt,
   output fpdiv_pre_pkg::unpacked_op_t    op
);

   import fpdiv_pre_pkg::*;

   // Exponent all ones, tested at the width of the chosen format
   logic exp_ones;

   always_comb
   begin
      case (fmt)
         FMT_FP16:
         begin
            op.sign  = operand[HALF_W-1];
            // Zero-extend the 5 bit exponent
            op.exp   = EXP_W'(operand[HALF_W-2 -: EXP_W_FP16]);
            // Pad mantissa at the bottom
            op.mant  = {operand[MANT_W_FP16-1:0], {(MANT_W-MANT_W_FP16){1'b0}}};
            exp_ones = &operand[HALF_W-2 -: EXP_W_FP16];
         end
         FMT_FP16ALT:
         begin
            op.sign  = operand[HALF_W-1];
            op.exp   = EXP_W'(operand[HALF_W-2 -: EXP_W_FP16ALT]);
            op.mant  = {operand[MANT_W_FP16ALT-1:0], {(MANT_W-MANT_W_FP16ALT){1'b0}}};
            exp_ones = &operand[HALF_W-2 -: EXP_W_FP16ALT];
         end
         default:
         begin
            // FP32, also taken for the unused code
            op.sign  = operand[OP_W-1];
            op.exp   = operand[OP_W-2 -: EXP_W];
            op.mant  = operand[MANT_W-1:0];
            exp_ones = &operand[OP_W-2 -: EXP_W];
         end
      endcase

      //////////////////////////////////////////////////
      // Raw field flags
      //////////////////////////////////////////////////

      // Hidden bit set for any nonzero exponent
      op.hidden       = |op.exp;
      op.exp_ones     = exp_ones;
      // Padding is zero, so this is the format mantissa test
      op.mant_zero    = ~(|op.mant);
      // Quiet bit of a NaN sits at the top of the padded mantissa
      op.mant_msb     = op.mant[MANT_W-1];
      op.mant_rest_nz = |op.mant[MANT_W-2:0];
   end

endmodule

// File: hw/preprocess/special_case_detect.sv
// Special-case classifier
// Turns the raw field flags of both operands into zero/inf/NaN/sNaN flags
// and raises the strobe for operations that need the iterative datapath

`timescale 1ns/1ns

module special_case_detect
(
   input  fpdiv_pre_pkg::unpacked_op_t op_a,
   input  fpdiv_pre_pkg::unpacked_op_t op_b,
   input  logic                        div_start,
   input  logic                        accept,
   output fpdiv_pre_pkg::class_flags_t flags,
   output logic                        normal_op
);

   import fpdiv_pre_pkg::*;

   // Signalling NaN per operand
   logic snan_a;
   logic snan_b;
   // Any special case for each operation type
   logic div_special;
   logic sqrt_special;

   //////////////////////////////////////////////////
   // Classification
   //////////////////////////////////////////////////

   // Zero exponent and zero mantissa
   assign flags.zero_a = ~op_a.hidden & op_a.mant_zero;
   assign flags.zero_b = ~op_b.hidden & op_b.mant_zero;
   // All-ones exponent splits into inf and NaN on the mantissa
   assign flags.inf_a  = op_a.exp_ones & op_a.mant_zero;
   assign flags.inf_b  = op_b.exp_ones & op_b.mant_zero;
   assign flags.nan_a  = op_a.exp_ones & ~op_a.mant_zero;
   assign flags.nan_b  = op_b.exp_ones & ~op_b.mant_zero;

   // Quiet bit clear with payload left below it
   assign snan_a = op_a.exp_ones & ~op_a.mant_msb & op_a.mant_rest_nz;
   assign snan_b = op_b.exp_ones & ~op_b.mant_msb & op_b.mant_rest_nz;
   assign flags.snan = snan_a | snan_b;

   //////////////////////////////////////////////////
   // Normal path strobe
   //////////////////////////////////////////////////

   assign div_special  = flags.zero_a | flags.zero_b | flags.inf_a | flags.inf_b |
                         flags.nan_a | flags.nan_b;
   // Square root looks at operand a only, negative input is invalid
   assign sqrt_special = flags.zero_a | flags.inf_a | flags.nan_a | op_a.sign;

   // Divide wins when both starts are high
   assign normal_op = accept & ~(div_start ? div_special : sqrt_special);

endmodule

// File: hw/preprocess/mant_normalizer.sv
// Mantissa normalizer
// Counts leading zeros of one mantissa, moves the leading one to the hidden
// bit position and adjusts the exponent, captured on accept

`timescale 1ns/1ns

module mant_normalizer
(
   input  logic                                  Clk_CI,
   input  logic                                  Rst_RBI,
   input  logic                                  accept,
   input  fpdiv_pre_pkg::unpacked_op_t           op,
   output logic [fpdiv_pre_pkg::NEXP_W-1:0]      exp_norm,
   output logic [fpdiv_pre_pkg::NMANT_W-1:0]     mant_norm
);

   import fpdiv_pre_pkg::*;

   // Hidden bit in front of the padded mantissa
   logic [NMANT_W-1:0] mant_full;
   logic [LZC_W-1:0]   lzc;
   logic [NMANT_W-1:0] mant_shift;
   logic [NEXP_W-1:0]  exp_adj;

   assign mant_full = {op.hidden, op.mant};

   //////////////////////////////////////////////////
   // Leading-zero count
   //////////////////////////////////////////////////

   // Priority scan from the bottom, the highest one wins
   // All-zero mantissa keeps a count of zero
   always_comb
   begin
      lzc = '0;
      for (int i = 0; i < NMANT_W; i++)
      begin
         if (mant_full[i])
            lzc = LZC_W'(NMANT_W - 1 - i);
      end
   end

   //////////////////////////////////////////////////
   // Shift and exponent adjust
   //////////////////////////////////////////////////

   assign mant_shift = mant_full << lzc;

   // Subnormals carry an effective exponent of one, hence the +1
   // Result may go negative and wraps at 9 bits
   assign exp_adj = {1'b0, op.exp} - NEXP_W'(lzc) + NEXP_W'(lzc != '0);

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         exp_norm  <= '0;
         mant_norm <= '0;
      end
      else if (accept)
      begin
         exp_norm  <= exp_adj;
         mant_norm <= mant_shift;
      end
   end

endmodule

// File: hw/preprocess/result_register.sv
// Result register
// Picks the result sign by operation and captures sign, rounding mode and
// class flags on accept, holding them until the next accept

`timescale 1ns/1ns

module result_register
(
   input  logic                        Clk_CI,
   input  logic                        Rst_RBI,
   input  logic                        accept,
   input  logic                        div_start,
   input  logic                        sign_a,
   input  logic                        sign_b,
   input  fpdiv_pre_pkg::rm_e          rm,
   input  fpdiv_pre_pkg::class_flags_t flags,
   output logic                        sign_z,
   output fpdiv_pre_pkg::rm_e          rm_q,
   output fpdiv_pre_pkg::class_flags_t flags_q
);

   import fpdiv_pre_pkg::*;

   logic sign_sel;

   //////////////////////////////////////////////////
   // Result sign
   //////////////////////////////////////////////////

   // Divide takes the XOR, square root keeps the sign of a
   always_comb
   begin
      if (div_start)
         sign_sel = sign_a ^ sign_b;
      else
         sign_sel = sign_a;
   end

   //////////////////////////////////////////////////
   // Capture on accept
   //////////////////////////////////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         sign_z  <= 1'b0;
         rm_q    <= RM_RNE;
         flags_q <= '0;
      end
      else if (accept)
      begin
         sign_z  <= sign_sel;
         rm_q    <= rm;
         flags_q <= flags;
      end
   end

endmodule

// File: hw/preprocess_top.sv
// Operand preparation stage for the iterative divide/square-root unit
// Unpacks and classifies both operands, normalizes subnormal mantissas and
// registers everything the core needs on accept

`timescale 1ns/1ns

module preprocess_top
(
   input  logic                           Clk_CI,
   input  logic                           Rst_RBI,
   input  logic                           div_start,
   input  logic                           sqrt_start,
   input  logic                           ready,
   input  logic [fpdiv_pre_pkg::OP_W-1:0] operand_a,
   input  logic [fpdiv_pre_pkg::OP_W-1:0] operand_b,
   input  fpdiv_pre_pkg::fmt_e            fmt,
   input  fpdiv_pre_pkg::rm_e             rm,
   output logic                           normal_op,
   output fpdiv_pre_pkg::pre_result_t     result
);

   import fpdiv_pre_pkg::*;

   // Operation taken this cycle
   logic               accept;
   unpacked_op_t       op_a;
   unpacked_op_t       op_b;
   class_flags_t       flags;
   class_flags_t       flags_q;
   logic               sign_z;
   rm_e                rm_q;
   logic [NEXP_W-1:0]  exp_a_norm;
   logic [NEXP_W-1:0]  exp_b_norm;
   logic [NMANT_W-1:0] mant_a_norm;
   logic [NMANT_W-1:0] mant_b_norm;

   assign accept = (div_start | sqrt_start) & ready;

   //////////////////////////////////////////////////
   // Input side, operand unpackers
   //////////////////////////////////////////////////

   operand_unpack u_unpack_a (.operand(operand_a), .fmt(fmt), .op(op_a));
   operand_unpack u_unpack_b (.operand(operand_b), .fmt(fmt), .op(op_b));

   //////////////////////////////////////////////////
   // Classifier and normalizers
   //////////////////////////////////////////////////

   special_case_detect u_special_case_detect (
      .op_a      (op_a),
      .op_b      (op_b),
      .div_start (div_start),
      .accept    (accept),
      .flags     (flags),
      .normal_op (normal_op)
   );

   mant_normalizer u_norm_a (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .accept    (accept),
      .op        (op_a),
      .exp_norm  (exp_a_norm),
      .mant_norm (mant_a_norm)
   );

   mant_normalizer u_norm_b (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .accept    (accept),
      .op        (op_b),
      .exp_norm  (exp_b_norm),
      .mant_norm (mant_b_norm)
   );

   //////////////////////////////////////////////////
   // Output side, result register
   //////////////////////////////////////////////////

   result_register u_result_register (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .accept    (accept),
      .div_start (div_start),
      .sign_a    (op_a.sign),
      .sign_b    (op_b.sign),
      .rm        (rm),
      .flags     (flags),
      .sign_z    (sign_z),
      .rm_q      (rm_q),
      .flags_q   (flags_q)
   );

   // All fields come from registers, valid one cycle after accept
   assign result = '{
      sign_z : sign_z,
      rm     : rm_q,
      flags  : flags_q,
      exp_a  : exp_a_norm,
      exp_b  : exp_b_norm,
      mant_a : mant_a_norm,
      mant_b : mant_b_norm
   };

endmodule

// File: verification/preprocess_sva.sv
// Assertions on the result register
// Outputs hold without accept and the captured sign follows the operation

`timescale 1ns/1ns

module preprocess_sva
(
   input logic                        Clk_CI,
   input logic                        Rst_RBI,
   input logic                        accept,
   input logic                        div_start,
   input logic                        sign_a,
   input logic                        sign_b,
   input logic                        sign_z,
   input fpdiv_pre_pkg::rm_e          rm_q,
   input fpdiv_pre_pkg::class_flags_t flags_q
);

   import fpdiv_pre_pkg::*;

   // Number of failed assertions so far
   int fail_count = 0;

   // Nothing moves after a cycle without accept
   property p_hold_without_accept;
      @(posedge Clk_CI) disable iff (~Rst_RBI)
      !accept |=> ($stable(sign_z) && $stable(rm_q) && $stable(flags_q));
   endproperty

   // Divide sign is the XOR of both operand signs
   property p_div_sign;
      @(posedge Clk_CI) disable iff (~Rst_RBI)
      (accept && div_start) |=> (sign_z == ($past(sign_a) ^ $past(sign_b)));
   endproperty

   // Square root keeps the sign of operand a
   property p_sqrt_sign;
      @(posedge Clk_CI) disable iff (~Rst_RBI)
      (accept && !div_start) |=> (sign_z == $past(sign_a));
   endproperty

   a_hold_without_accept : assert property (p_hold_without_accept)
      else
      begin
         $error("Result register changed in a cycle without accept");
         fail_count++;
      end
   a_div_sign : assert property (p_div_sign)
      else
      begin
         $error("Divide result sign is not the XOR of the operand signs");
         fail_count++;
      end
   a_sqrt_sign : assert property (p_sqrt_sign)
      else
      begin
         $error("Square root result sign differs from the sign of operand a");
         fail_count++;
      end

endmodule

bind result_register preprocess_sva u_preprocess_sva (
   .Clk_CI    (Clk_CI),
   .Rst_RBI   (Rst_RBI),
   .accept    (accept),
   .div_start (div_start),
   .sign_a    (sign_a),
   .sign_b    (sign_b),
   .sign_z    (sign_z),
   .rm_q      (rm_q),
   .flags_q   (flags_q)
);

// File: verification/tb_preprocess.sv
// Testbench for the operand preparation stage
// Reads inputs and expected outputs from the stimulus file, drives one line
// per cycle and checks the strobe and the registered result

`timescale 1ns/1ns

module tb_preprocess;

   import fpdiv_pre_pkg::*;

   // One stimulus line, inputs followed by expected outputs
   typedef struct packed {
      logic              div;
      logic              sqrt;
      logic              rdy;
      logic [1:0]        fmt;
      logic [2:0]        rm;
      logic [OP_W-1:0]   a;
      logic [OP_W-1:0]   b;
      logic              normal_op;
      pre_result_t       res;
   } vec_t;

   logic            Clk_CI;
   logic            Rst_RBI;
   logic            div_start;
   logic            sqrt_start;
   logic            ready;
   logic [OP_W-1:0] operand_a;
   logic [OP_W-1:0] operand_b;
   fmt_e            fmt;
   rm_e             rm;
   logic            normal_op;
   pre_result_t     result;

   vec_t vecs[$];
   int   errors = 0;
   logic vectors_loaded = 1'b0;

   preprocess_top u_preprocess_top (
      .Clk_CI     (Clk_CI),
      .Rst_RBI    (Rst_RBI),
      .div_start  (div_start),
      .sqrt_start (sqrt_start),
      .ready      (ready),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .fmt        (fmt),
      .rm         (rm),
      .normal_op  (normal_op),
      .result     (result)
   );

   // 10 ns clock
   always #5 Clk_CI = ~Clk_CI;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                  $time, name, actual, expected);
         errors++;
         $display("SOME TESTS FAILED");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   // Field by field, so a mismatch names the field
   task automatic compare_result(input pre_result_t exp_res);
      check_value("result.sign_z", result.sign_z, exp_res.sign_z);
      check_value("result.rm", result.rm, exp_res.rm);
      check_value("result.flags", result.flags, exp_res.flags);
      check_value("result.exp_a", result.exp_a, exp_res.exp_a);
      check_value("result.exp_b", result.exp_b, exp_res.exp_b);
      check_value("result.mant_a", result.mant_a, exp_res.mant_a);
      check_value("result.mant_b", result.mant_b, exp_res.mant_b);
   endtask

   task automatic apply_inputs(input vec_t v);
      div_start  <= v.div;
      sqrt_start <= v.sqrt;
      ready      <= v.rdy;
      fmt        <= fmt_e'(v.fmt);
      rm         <= rm_e'(v.rm);
      operand_a  <= v.a;
      operand_b  <= v.b;
   endtask

   // Lines starting with # and blank lines are skipped
   task automatic load_vectors();
      int          fd;
      int          n;
      int          line_no;
      string       line;
      vec_t        v;
      logic [31:0] c_div, c_sqrt, c_rdy, c_fmt, c_rm, c_a, c_b, c_nop;
      logic [31:0] c_sign, c_rmq, c_flags, c_expa, c_expb, c_manta, c_mantb;
      line_no = 0;
      fd = $fopen("verification/preprocess_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file verification/preprocess_stimulus.txt");
         $display("SOME TESTS FAILED");
         $fatal(1, "Missing stimulus file");
      end
      while ($fgets(line, fd) != 0)
      begin
         line_no++;
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     c_div, c_sqrt, c_rdy, c_fmt, c_rm, c_a, c_b, c_nop,
                     c_sign, c_rmq, c_flags, c_expa, c_expb, c_manta, c_mantb);
         if (n != 15)
         begin
            $display("Stimulus line %0d has %0d fields instead of 15", line_no, n);
            $display("SOME TESTS FAILED");
            $fatal(1, "Bad stimulus line");
         end
         v.div        = c_div[0];
         v.sqrt       = c_sqrt[0];
         v.rdy        = c_rdy[0];
         v.fmt        = c_fmt[1:0];
         v.rm         = c_rm[2:0];
         v.a          = c_a;
         v.b          = c_b;
         v.normal_op  = c_nop[0];
         v.res.sign_z = c_sign[0];
         v.res.rm     = rm_e'(c_rmq[2:0]);
         v.res.flags  = c_flags[6:0];
         v.res.exp_a  = c_expa[NEXP_W-1:0];
         v.res.exp_b  = c_expb[NEXP_W-1:0];
         v.res.mant_a = c_manta[NMANT_W-1:0];
         v.res.mant_b = c_mantb[NMANT_W-1:0];
         vecs.push_back(v);
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////

   initial
   begin
      wait (vectors_loaded);
      repeat (vecs.size() * 3 + 20) @(posedge Clk_CI);
      $display("Timeout: the run did not finish within %0d cycles", vecs.size() * 3 + 20);
      $display("SOME TESTS FAILED");
      $fatal(1, "Watchdog expired");
   end

   //////////////////////////////////////////////////
   // Assertion monitor
   //////////////////////////////////////////////////

   // Bound assertions count their failures, stop at the first one
   always @(u_preprocess_top.u_result_register.u_preprocess_sva.fail_count)
   begin
      if (u_preprocess_top.u_result_register.u_preprocess_sva.fail_count != 0)
      begin
         $display("An assertion on the result register failed at %0t ns", $time);
         $display("SOME TESTS FAILED");
         $fatal(1, "Assertion failure");
      end
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      Clk_CI     = 1'b0;
      Rst_RBI    = 1'b0;
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      ready      = 1'b0;
      operand_a  = '0;
      operand_b  = '0;
      fmt        = FMT_FP32;
      rm         = RM_RNE;

      load_vectors();
      vectors_loaded = 1'b1;

      repeat (8) @(posedge Clk_CI);
      Rst_RBI <= 1'b1;

      // Reset values
      @(negedge Clk_CI);
      check_value("normal_op", normal_op, 1'b0);
      compare_result('0);

      // Strobe of line i in its own cycle, result of line i-1 from the edge before
      for (int i = 0; i < vecs.size(); i++)
      begin
         @(posedge Clk_CI);
         apply_inputs(vecs[i]);
         @(negedge Clk_CI);
         check_value("normal_op", normal_op, vecs[i].normal_op);
         if (i > 0)
            compare_result(vecs[i-1].res);
      end

      // One idle cycle to see the last result
      @(posedge Clk_CI);
      div_start  <= 1'b0;
      sqrt_start <= 1'b0;
      @(negedge Clk_CI);
      check_value("normal_op", normal_op, 1'b0);
      if (vecs.size() > 0)
         compare_result(vecs[vecs.size()-1].res);

      // One more edge so the assertions see the last capture
      @(posedge Clk_CI);
      @(negedge Clk_CI);

      if (errors == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("SOME TESTS FAILED");
         $fatal(1, "Checks failed");
      end
   end

endmodule

// File: verification/preprocess_stimulus.txt
# Hex columns: div sqrt ready fmt rm a b, then expected normal_op sign_z rm flags exp_a exp_b mant_a mant_b
# flags bits 6..0 are zero_a zero_b inf_a inf_b nan_a nan_b snan
1 0 1 0 1 3FC00000 C0000000 1 1 1 00 07F 080 C00000 800000
0 1 1 0 0 40800000 00000000 1 0 0 20 081 000 800000 000000
1 0 1 2 2 00000001 00003C00 1 0 2 00 1F7 00F 800000 800000
1 0 1 2 3 00008200 00004248 1 1 3 00 000 010 800000 C90000
0 1 1 3 4 00000003 00000040 1 0 4 00 1FB 000 C00000 800000
1 0 1 3 0 FFFFBF80 00004049 1 1 0 00 07F 080 800000 C90000
1 0 1 0 0 00000000 3F800000 0 0 0 40 000 07F 000000 800000
1 0 1 0 1 7F800000 80000000 0 1 1 30 0FF 000 800000 000000
1 0 1 0 2 3F800000 7FC00000 0 0 2 02 07F 0FF 800000 C00000
1 0 1 0 3 FF800001 40000000 0 1 3 05 0FF 080 800001 800000
1 0 1 2 4 00007C00 0000FD00 0 1 4 13 01F 01F 800000 A00000
0 1 1 3 0 00007FC0 00000000 0 0 0 24 0FF 000 C00000 000000
0 1 1 0 1 C0800000 3F800000 0 1 1 00 081 07F 800000 800000
1 0 0 0 2 3F800000 3F800000 0 1 1 00 081 07F 800000 800000
0 0 1 0 3 12345678 00000000 0 1 1 00 081 07F 800000 800000
1 1 1 0 4 40000000 80000000 0 1 4 20 080 000 800000 000000
1 0 1 0 0 00000001 00400000 1 0 0 00 1EA 000 800000 800000
0 1 1 1 2 41100000 BF800000 1 0 2 00 082 07F 900000 800000
0 1 0 0 3 FF800000 00000000 0 0 2 00 082 07F 900000 800000
0 1 1 2 1 ABCD4400 00000000 1 0 1 20 011 000 800000 000000
1 0 1 2 3 000003FF 00008001 1 1 3 00 000 1F7 FFC000 800000
1 0 1 3 4 0000FF80 00003F80 0 1 4 10 0FF 07F 800000 800000
1 0 1 2 0 00008000 0000FC00 0 0 0 48 000 01F 000000 800000

// File: flist.f
common/fpdiv_pre_pkg.sv
hw/preprocess/operand_unpack.sv
hw/preprocess/special_case_detect.sv
hw/preprocess/mant_normalizer.sv
hw/preprocess/result_register.sv
hw/preprocess_top.sv
verification/preprocess_sva.sv
verification/tb_preprocess.sv
